// File: design/mem_wormhole_pkg.sv
// Memory wormhole types
`default_nettype none

package mem_wormhole_pkg;

  localparam int cord_width_c = 4;
  localparam int cid_width_c  = 2;
  localparam int len_width_c  = 5;
  localparam int addr_width_c = 40;
  localparam int data_width_c = 256;

  typedef enum logic [2:0] {
    e_mem_rd    = 3'd0,
    e_mem_wr    = 3'd1,
    e_mem_uc_rd = 3'd2,
    e_mem_uc_wr = 3'd3,
    e_mem_wb    = 3'd4,
    e_mem_inv   = 3'd5  // codes 6 and 7 unused.
  } mem_msg_e;

  typedef enum logic [2:0] {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5
  } mem_size_e;

  // data is the top field so a short packet only drops data bytes.
  typedef struct packed {
    logic [data_width_c-1:0] data;  // byte 0 in low bits.
    logic [addr_width_c-1:0] addr;
    mem_size_e               size;
    mem_msg_e                msg_type;
  } mem_cmd_s;

  typedef struct packed {
    mem_cmd_s                cmd;
    logic [cord_width_c-1:0] src_cord;
    logic [cid_width_c-1:0]  src_cid;
    logic [1:0]              reserved;  // always zero.
  } mem_payload_s;

  // cord sits lowest, so flit 0 holds the routing fields.
  typedef struct packed {
    mem_payload_s           payload;
    logic [len_width_c-1:0] len;  // flits after the first.
    logic [cid_width_c-1:0] cid;
    logic [cord_width_c-1:0] cord;
  } mem_packet_s;

  localparam int packet_width_c = $bits(mem_packet_s);
  localparam int header_width_c = packet_width_c - data_width_c;

endpackage

`default_nettype wire

// File: design/mem_cmd_packet_encode.sv
// Command packet encoder
`timescale 1ns/10ps
`default_nettype none

module mem_cmd_packet_encode
  import mem_wormhole_pkg::*;
#(
  parameter int flit_width_p = 32
) (
  input  mem_cmd_s                cmd_i,
  input  logic [cord_width_c-1:0] src_cord_i,
  input  logic [cid_width_c-1:0]  src_cid_i,
  input  logic [cord_width_c-1:0] dst_cord_i,
  input  logic [cid_width_c-1:0]  dst_cid_i,
  output mem_packet_s             packet_o,
  output logic                    packet_v_o
);

  // flits after the first for a packet of the given bit count.
  function automatic int flit_len(input int bits);
    return (bits + flit_width_p - 1) / flit_width_p - 1;
  endfunction

  localparam int req_len_lp     = flit_len(header_width_c);
  localparam int data_len_1_lp  = flit_len(header_width_c + 8 * 1);
  localparam int data_len_2_lp  = flit_len(header_width_c + 8 * 2);
  localparam int data_len_4_lp  = flit_len(header_width_c + 8 * 4);
  localparam int data_len_8_lp  = flit_len(header_width_c + 8 * 8);
  localparam int data_len_16_lp = flit_len(header_width_c + 8 * 16);
  localparam int data_len_32_lp = flit_len(header_width_c + 8 * 32);

  mem_payload_s           payload;
  logic [len_width_c-1:0] data_len;

  always_comb begin
    payload.cmd      = cmd_i;
    payload.src_cord = src_cord_i;
    payload.src_cid  = src_cid_i;
    payload.reserved = '0;

    case (cmd_i.size)
      e_size_1:  data_len = len_width_c'(data_len_1_lp);
      e_size_2:  data_len = len_width_c'(data_len_2_lp);
      e_size_4:  data_len = len_width_c'(data_len_4_lp);
      e_size_8:  data_len = len_width_c'(data_len_8_lp);
      e_size_16: data_len = len_width_c'(data_len_16_lp);
      default:   data_len = len_width_c'(data_len_32_lp);  // full block.
    endcase

    packet_o.payload = payload;
    packet_o.cord    = dst_cord_i;
    packet_o.cid     = dst_cid_i;
    packet_o.len     = len_width_c'(req_len_lp);
    packet_v_o       = 1'b1;

    case (cmd_i.msg_type)
      e_mem_rd, e_mem_wr, e_mem_uc_rd, e_mem_inv: begin
        packet_o.len = len_width_c'(req_len_lp);  // header only.
      end
      e_mem_uc_wr, e_mem_wb: begin
        packet_o.len = data_len;
      end
      default: begin
        packet_o   = '0;  // unknown type, dropped.
        packet_v_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/wormhole_flit_serialize.sv
// Wormhole flit serializer
`timescale 1ns/10ps
`default_nettype none

module wormhole_flit_serialize
  import mem_wormhole_pkg::*;
#(
  parameter int flit_width_p = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    v_i,
  input  mem_packet_s             packet_i,
  output logic                    ready_o,
  output logic [flit_width_p-1:0] flit_o,
  output logic                    flit_v_o
);

  localparam int num_flits_lp   = (packet_width_c + flit_width_p - 1) / flit_width_p;
  localparam int shift_width_lp = num_flits_lp * flit_width_p;

  logic [shift_width_lp-1:0] shift_r;
  logic [len_width_c-1:0]    cnt_r;
  logic                      busy_r;
  logic                      accept;

  assign accept = v_i && !busy_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end else if (accept) begin
      busy_r <= 1'b1;
      cnt_r  <= packet_i.len;  // flits left after flit 0.
    end else if (busy_r) begin
      if (cnt_r == '0) begin
        busy_r <= 1'b0;  // last flit out.
      end else begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_r <= shift_width_lp'(packet_i);
    end else if (busy_r) begin
      shift_r <= shift_r >> flit_width_p;  // next flit to the bottom.
    end
  end

  assign ready_o  = !busy_r;
  assign flit_v_o = busy_r;
  assign flit_o   = shift_r[flit_width_p-1:0];

endmodule

`default_nettype wire

// File: design/wormhole_flit_deserialize.sv
// Wormhole flit deserializer
`timescale 1ns/10ps
`default_nettype none

module wormhole_flit_deserialize
  import mem_wormhole_pkg::*;
#(
  parameter int flit_width_p = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [flit_width_p-1:0] flit_i,
  input  logic                    flit_v_i,
  output mem_packet_s             packet_o,
  output logic                    packet_v_o
);

  localparam int num_flits_lp = (packet_width_c + flit_width_p - 1) / flit_width_p;
  localparam int asm_width_lp = num_flits_lp * flit_width_p;

  logic [flit_width_p-1:0] flit_r;
  logic                    flit_v_r;
  logic [asm_width_lp-1:0] asm_r;
  logic [len_width_c-1:0]  len_r;
  logic [len_width_c-1:0]  idx_r;
  logic                    first_r;
  logic                    done_r;
  mem_packet_s             head;

  // routing fields of a first flit.
  assign head = mem_packet_s'(packet_width_c'(flit_r));

  always_ff @(posedge clk_i) begin
    flit_r <= flit_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      flit_v_r <= 1'b0;
      first_r  <= 1'b1;
      done_r   <= 1'b0;
      len_r    <= '0;
      idx_r    <= '0;
    end else begin
      flit_v_r <= flit_v_i;
      done_r   <= 1'b0;
      if (flit_v_r) begin
        if (first_r) begin
          len_r <= head.len;
          idx_r <= len_width_c'(1);
          if (head.len == '0) begin
            done_r <= 1'b1;  // single flit packet.
          end else begin
            first_r <= 1'b0;
          end
        end else begin
          idx_r <= idx_r + 1'b1;
          if (idx_r == len_r) begin
            done_r  <= 1'b1;
            first_r <= 1'b1;
          end
        end
      end
    end
  end

  // unsent slots stay zero from the clear on flit 0.
  always_ff @(posedge clk_i) begin
    if (flit_v_r) begin
      if (first_r) begin
        asm_r <= asm_width_lp'(flit_r);
      end else begin
        asm_r[idx_r*flit_width_p +: flit_width_p] <= flit_r;
      end
    end
  end

  assign packet_o   = mem_packet_s'(asm_r[packet_width_c-1:0]);
  assign packet_v_o = done_r;

endmodule

`default_nettype wire

// File: design/mem_cmd_packet_decode.sv
// Command packet decoder
`timescale 1ns/10ps
`default_nettype none

module mem_cmd_packet_decode
  import mem_wormhole_pkg::*;
#(
  parameter logic [cord_width_c-1:0] my_cord_p = '0,
  parameter logic [cid_width_c-1:0]  my_cid_p  = '0
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  mem_packet_s             packet_i,
  input  logic                    packet_v_i,
  output logic                    cmd_v_o,
  output mem_cmd_s                cmd_o,
  output logic [cord_width_c-1:0] src_cord_o,
  output logic [cid_width_c-1:0]  src_cid_o,
  output logic                    dst_miss_o
);

  logic hit;

  assign hit = (packet_i.cord == my_cord_p) && (packet_i.cid == my_cid_p);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_v_o    <= 1'b0;
      dst_miss_o <= 1'b0;
    end else begin
      cmd_v_o    <= packet_v_i && hit;
      dst_miss_o <= packet_v_i && !hit;  // not for this node.
    end
  end

  // outputs hold their last value on a miss.
  always_ff @(posedge clk_i) begin
    if (packet_v_i && hit) begin
      cmd_o      <= packet_i.payload.cmd;
      src_cord_o <= packet_i.payload.src_cord;
      src_cid_o  <= packet_i.payload.src_cid;
    end
  end

endmodule

`default_nettype wire

// File: design/mem_cmd_wormhole_link.sv
// Memory command wormhole link
`timescale 1ns/10ps
`default_nettype none

module mem_cmd_wormhole_link
  import mem_wormhole_pkg::*;
#(
  parameter int                      flit_width_p = 32,
  parameter logic [cord_width_c-1:0] my_cord_p    = '0,
  parameter logic [cid_width_c-1:0]  my_cid_p     = '0
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_v_i,
  input  mem_cmd_s                cmd_i,
  input  logic [cord_width_c-1:0] dst_cord_i,
  input  logic [cid_width_c-1:0]  dst_cid_i,
  output logic                    cmd_ready_o,
  output logic [flit_width_p-1:0] link_flit_o,
  output logic                    link_v_o,
  input  logic [flit_width_p-1:0] link_flit_i,
  input  logic                    link_v_i,
  output logic                    cmd_v_o,
  output mem_cmd_s                cmd_o,
  output logic [cord_width_c-1:0] src_cord_o,
  output logic [cid_width_c-1:0]  src_cid_o,
  output logic                    dst_miss_o
);

  mem_packet_s enc_packet;
  logic        enc_packet_v;
  mem_packet_s rx_packet;
  logic        rx_packet_v;

  mem_cmd_packet_encode #(
    .flit_width_p(flit_width_p)
  ) i_mem_cmd_packet_encode (
    .cmd_i      (cmd_i),
    .src_cord_i (my_cord_p),  // source is this node.
    .src_cid_i  (my_cid_p),
    .dst_cord_i (dst_cord_i),
    .dst_cid_i  (dst_cid_i),
    .packet_o   (enc_packet),
    .packet_v_o (enc_packet_v)
  );

  wormhole_flit_serialize #(
    .flit_width_p(flit_width_p)
  ) i_wormhole_flit_serialize (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .v_i      (cmd_v_i & enc_packet_v),  // unknown types dropped.
    .packet_i (enc_packet),
    .ready_o  (cmd_ready_o),
    .flit_o   (link_flit_o),
    .flit_v_o (link_v_o)
  );

  wormhole_flit_deserialize #(
    .flit_width_p(flit_width_p)
  ) i_wormhole_flit_deserialize (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flit_i     (link_flit_i),
    .flit_v_i   (link_v_i),
    .packet_o   (rx_packet),
    .packet_v_o (rx_packet_v)
  );

  mem_cmd_packet_decode #(
    .my_cord_p(my_cord_p),
    .my_cid_p (my_cid_p)
  ) i_mem_cmd_packet_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .packet_i   (rx_packet),
    .packet_v_i (rx_packet_v),
    .cmd_v_o    (cmd_v_o),
    .cmd_o      (cmd_o),
    .src_cord_o (src_cord_o),
    .src_cid_o  (src_cid_o),
    .dst_miss_o (dst_miss_o)
  );

endmodule

`default_nettype wire

// File: verification/mem_cmd_wormhole_link_properties.sv
// Link port properties
`timescale 1ns/10ps
`default_nettype none

module mem_cmd_wormhole_link_properties
  import mem_wormhole_pkg::*;
#(
  parameter int flit_width_p = 32
) (
  input logic clk_i,
  input logic rst_n_i,
  input logic cmd_v_i,
  input logic cmd_ready_i,
  input logic tx_v_i,
  input logic out_v_i,
  input logic miss_i
);

  // no packet is shorter than its header.
  localparam int min_flits_lp = (header_width_c + flit_width_p - 1) / flit_width_p;

  int fail_cnt = 0;

  strobe_only_when_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_v_i |-> cmd_ready_i)
    else begin
      $error("command strobe while cmd_ready_o is low");
      fail_cnt++;
    end

  flit_run_unbroken: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(tx_v_i) |-> tx_v_i [*min_flits_lp])
    else begin
      $error("link_v_o run shorter than a header");
      fail_cnt++;
    end

  hit_or_miss: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(out_v_i && miss_i))
    else begin
      $error("cmd_v_o and dst_miss_o high together");
      fail_cnt++;
    end

  idle_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> (!tx_v_i && !out_v_i && !miss_i && cmd_ready_i))
    else begin
      $error("outputs active in the cycle after reset");
      fail_cnt++;
    end

endmodule

bind mem_cmd_wormhole_link mem_cmd_wormhole_link_properties #(
  .flit_width_p(flit_width_p)
) i_mem_cmd_wormhole_link_properties (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .cmd_v_i    (cmd_v_i),
  .cmd_ready_i(cmd_ready_o),
  .tx_v_i     (link_v_o),
  .out_v_i    (cmd_v_o),
  .miss_i     (dst_miss_o)
);

`default_nettype wire

// File: verification/mem_cmd_wormhole_link_tb.sv
// Wormhole link testbench
`timescale 1ns/10ps
`default_nettype none

module mem_cmd_wormhole_link_tb
  import mem_wormhole_pkg::*;
();

  localparam int                      flit_width_c      = 32;
  localparam logic [cord_width_c-1:0] my_cord_c         = 4'h5;
  localparam logic [cid_width_c-1:0]  my_cid_c          = 2'h1;
  localparam int                      header_bits_c     = 65;  // routing, payload, command.
  localparam int                      num_cmds_c        = 92;
  localparam int                      watchdog_cycles_c = num_cmds_c * 16 + 200;

  typedef struct packed {
    logic     miss;
    mem_cmd_s cmd;
  } expect_s;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    cmd_v;
  mem_cmd_s                cmd_in;
  logic [cord_width_c-1:0] dst_cord;
  logic [cid_width_c-1:0]  dst_cid;
  logic                    cmd_ready;
  logic [flit_width_c-1:0] link_flit;
  logic                    link_v;
  logic                    out_v;
  mem_cmd_s                cmd_out;
  logic [cord_width_c-1:0] src_cord;
  logic [cid_width_c-1:0]  src_cid;
  logic                    dst_miss;

  logic [31:0] lfsr = 32'hc589_adfd;
  expect_s     exp_q[$];
  int          len_q[$];
  expect_s     pending;
  int          run_len = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          errs_at_start = 0;

  always #10 clk = ~clk;

  mem_cmd_wormhole_link #(
    .flit_width_p(flit_width_c),
    .my_cord_p   (my_cord_c),
    .my_cid_p    (my_cid_c)
  ) i_mem_cmd_wormhole_link (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .cmd_v_i    (cmd_v),
    .cmd_i      (cmd_in),
    .dst_cord_i (dst_cord),
    .dst_cid_i  (dst_cid),
    .cmd_ready_o(cmd_ready),
    .link_flit_o(link_flit),
    .link_v_o   (link_v),
    .link_flit_i(link_flit),  // loopback.
    .link_v_i   (link_v),
    .cmd_v_o    (out_v),
    .cmd_o      (cmd_out),
    .src_cord_o (src_cord),
    .src_cid_o  (src_cid),
    .dst_miss_o (dst_miss)
  );

  // galois form, taps for x^32+x^22+x^2+x+1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [255:0] take_bits(input int n);
    logic [255:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  function automatic int expected_len(input mem_msg_e msg, input mem_size_e size);
    int bits;
    bits = header_bits_c;
    if (msg == e_mem_uc_wr || msg == e_mem_wb) begin
      bits += 8 * (1 << int'(size));  // data bytes travel too.
    end
    return (bits + flit_width_c - 1) / flit_width_c - 1;
  endfunction

  function automatic logic [data_width_c-1:0] keep_mask(input int len);
    int keep;
    keep = (len + 1) * flit_width_c - header_bits_c;  // data bits inside sent flits.
    if (keep >= data_width_c) begin
      return '1;
    end
    return ~({data_width_c{1'b1}} << keep);
  endfunction

  function automatic mem_cmd_s make_cmd(input logic [2:0] msg, input logic [2:0] size);
    mem_cmd_s c;
    c.msg_type = mem_msg_e'(msg);
    c.size     = mem_size_e'(size);
    c.addr     = addr_width_c'(take_bits(addr_width_c));
    c.data     = take_bits(data_width_c);
    return c;
  endfunction

  function automatic int total_errors();
    return err_cnt + i_mem_cmd_wormhole_link.i_mem_cmd_wormhole_link_properties.fail_cnt;
  endfunction

  task automatic compare(input string name, input logic [255:0] exp, input logic [255:0] act);
    check_cnt++;
    assert (act === exp) else begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  // called on a falling edge, returns on the falling edge after the strobe.
  task automatic send_cmd(input mem_cmd_s c, input logic [cord_width_c-1:0] cord,
                          input logic [cid_width_c-1:0] cid);
    expect_s e;
    int      len;
    while (!cmd_ready) begin
      @(negedge clk);
    end
    cmd_v    = 1'b1;
    cmd_in   = c;
    dst_cord = cord;
    dst_cid  = cid;
    if (int'(c.msg_type) < 6) begin
      len        = expected_len(c.msg_type, c.size);
      e.miss     = (cord != my_cord_c) || (cid != my_cid_c);
      e.cmd      = c;
      e.cmd.data = c.data & keep_mask(len);
      exp_q.push_back(e);
      len_q.push_back(len + 1);
    end
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || len_q.size() != 0 || !cmd_ready) begin
      @(negedge clk);
    end
  endtask

  task automatic start_test();
    errs_at_start = total_errors();
  endtask

  task automatic finish_test(input string name);
    drain();
    tests_run++;
    if (total_errors() == errs_at_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, total_errors() - errs_at_start);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && (out_v || dst_miss)) begin
      if (exp_q.size() == 0) begin
        $display("unexpected result on cmd_v_o or dst_miss_o with no command pending");
        err_cnt++;
      end else begin
        pending = exp_q.pop_front();
        compare("dst_miss_o", pending.miss, dst_miss);
        compare("cmd_v_o", !pending.miss, out_v);
        if (!pending.miss) begin
          compare("cmd_o.msg_type", pending.cmd.msg_type, cmd_out.msg_type);
          compare("cmd_o.size", pending.cmd.size, cmd_out.size);
          compare("cmd_o.addr", pending.cmd.addr, cmd_out.addr);
          compare("cmd_o.data", pending.cmd.data, cmd_out.data);
          compare("src_cord_o", my_cord_c, src_cord);
          compare("src_cid_o", my_cid_c, src_cid);
        end
      end
    end
  end

  // one run of link_v_o per packet.
  always @(posedge clk) begin
    if (rst_n) begin
      if (link_v) begin
        run_len++;
      end else if (run_len != 0) begin
        if (len_q.size() == 0) begin
          $display("unexpected flits: %0d link_v_o pulses with no command sent", run_len);
          err_cnt++;
        end else begin
          compare("link_v_o pulses", len_q.pop_front(), run_len);
        end
        run_len = 0;
      end
    end
  end

  initial begin
    repeat (watchdog_cycles_c) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles_c);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [2:0]              msg;
    logic [cord_width_c-1:0] cord;
    logic [cid_width_c-1:0]  cid;
    rst_n    = 1'b0;
    cmd_v    = 1'b0;
    cmd_in   = '0;
    dst_cord = '0;
    dst_cid  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test();
    for (int i = 0; i < 12; i++) begin
      msg = 3'(take_bits(2));
      if (msg == 3'd3) begin
        msg = 3'd5;  // inv in place of uc_wr.
      end
      send_cmd(make_cmd(msg, 3'(take_bits(3) % 6)), my_cord_c, my_cid_c);
    end
    finish_test("request commands");

    start_test();
    for (int s = 0; s < 6; s++) begin
      send_cmd(make_cmd(3'd3, 3'(s)), my_cord_c, my_cid_c);
      send_cmd(make_cmd(3'd4, 3'(s)), my_cord_c, my_cid_c);
    end
    finish_test("data commands");

    start_test();
    for (int m = 0; m < 6; m++) begin
      for (int s = 0; s < 6; s++) begin
        send_cmd(make_cmd(3'(m), 3'(s)), my_cord_c, my_cid_c);
      end
    end
    finish_test("flit count");

    start_test();
    for (int i = 0; i < 8; i++) begin
      cord = my_cord_c;
      cid  = my_cid_c;
      if (i % 2 == 0) begin
        cord = my_cord_c ^ 4'(take_bits(3) + 1);
      end else begin
        cid = my_cid_c ^ 2'(take_bits(1) + 1);
      end
      send_cmd(make_cmd(3'(take_bits(3) % 6), 3'(take_bits(3) % 6)), cord, cid);
    end
    finish_test("destination miss");

    start_test();
    for (int i = 0; i < 4; i++) begin
      send_cmd(make_cmd(3'(6 + i % 2), 3'(i)), my_cord_c, my_cid_c);
      compare("cmd_ready_o", 1, cmd_ready);
      repeat (16) @(negedge clk);  // longest packet fits well inside.
    end
    finish_test("unknown type");

    start_test();
    for (int i = 0; i < 20; i++) begin
      msg  = 3'(take_bits(3) % 6);
      cord = my_cord_c;
      cid  = my_cid_c;
      if (take_bits(2) == 0) begin
        cord = 4'(take_bits(4));
        cid  = 2'(take_bits(2));
      end
      send_cmd(make_cmd(msg, 3'(take_bits(3) % 6)), cord, cid);
    end
    finish_test("back-to-back commands");

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_cnt, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_cmd_wormhole_link.f
design/mem_wormhole_pkg.sv
design/mem_cmd_packet_encode.sv
design/wormhole_flit_serialize.sv
design/wormhole_flit_deserialize.sv
design/mem_cmd_packet_decode.sv
design/mem_cmd_wormhole_link.sv
verification/mem_cmd_wormhole_link_properties.sv
verification/mem_cmd_wormhole_link_tb.sv

// File: Makefile
# Verilator build and run for the memory command wormhole link.

TOP       ?= mem_cmd_wormhole_link_tb
FILELIST  ?= mem_cmd_wormhole_link.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := TEST RESULT: PASS

SOURCES := $(wildcard design/*.sv verification/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
